//--- hw/frontend_pkg.sv
package frontend_pkg;

    ////////////////////
    // widths
    ////////////////////

    // address and instruction width
    localparam int xlen = 32;
    // memory bus data width, two instructions per beat
    localparam int mem_data_width = 64;
    // response and reply tag width, tag 0 means no tag
    localparam int mem_tag_width = 4;
    // one owner entry per possible tag
    localparam int num_mem_tags = 16;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = '0;
    // pc step per fetched instruction
    localparam logic [xlen-1:0] inst_bytes = 32'd4;

    ////////////////////
    // enums
    ////////////////////

    // memory bus command encoding
    typedef enum logic [1:0] {
        bus_none  = 2'b00,
        bus_load  = 2'b01,
        bus_store = 2'b10
    } bus_command_e;

    // who issued the load behind a tag
    typedef enum logic [1:0] {
        owner_none  = 2'b00,
        owner_data  = 2'b01,
        owner_fetch = 2'b10
    } mem_owner_e;

    // fetch FSM states
    typedef enum logic {
        fetch_idle = 1'b0,
        fetch_wait = 1'b1
    } fetch_state_e;

    ////////////////////
    // packed structs
    ////////////////////

    // request on the data port and on the memory bus
    typedef struct packed {
        bus_command_e              command;
        logic [xlen-1:0]           addr;
        logic [mem_data_width-1:0] data;
    } mem_req_t;

    // load reply routed back to one requester
    typedef struct packed {
        logic                      valid;
        logic [mem_data_width-1:0] data;
    } mem_reply_t;

    // one fetched instruction with its pc
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_packet_t;

endpackage

//--- hw/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                          clock,
    input  logic                          reset,
    output logic                          fetch_request,
    output logic [frontend_pkg::xlen-1:0] fetch_addr,
    input  logic                          fetch_accepted,
    input  frontend_pkg::mem_reply_t      fetch_reply,
    output frontend_pkg::fetch_packet_t   fetch_packet
);

    ////////////////////
    // state
    ////////////////////

    // fetch FSM
    frontend_pkg::fetch_state_e state;
    frontend_pkg::fetch_state_e state_next;

    // program counter of the instruction being fetched
    logic [frontend_pkg::xlen-1:0] pc;
    logic [frontend_pkg::xlen-1:0] pc_next;

    // reply handed back for our outstanding fetch
    logic reply_taken;

    // instruction half of the returned beat
    logic [frontend_pkg::xlen-1:0] reply_inst;

    // fetch packet register
    logic                          packet_valid;
    logic [frontend_pkg::xlen-1:0] packet_pc;
    logic [frontend_pkg::xlen-1:0] packet_inst;

    ////////////////////
    // bus request
    ////////////////////

    // request is a level, held until the arbiter accepts it
    assign fetch_request = (state == frontend_pkg::fetch_idle);

    // address always follows the pc
    assign fetch_addr = pc;

    ////////////////////
    // reply handling
    ////////////////////

    // only one fetch in flight, so any routed reply is ours
    assign reply_taken = (state == frontend_pkg::fetch_wait) && fetch_reply.valid;

    // the 64-bit beat holds two words
    // pc bit 2 picks the upper one
    always_comb begin
        if (pc[2]) begin
            reply_inst = fetch_reply.data[2*frontend_pkg::xlen-1:frontend_pkg::xlen];
        end else begin
            reply_inst = fetch_reply.data[frontend_pkg::xlen-1:0];
        end
    end

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        state_next = state;
        pc_next    = pc;
        case (state)
            frontend_pkg::fetch_idle: begin
                // request went out on the bus this cycle
                if (fetch_accepted) begin
                    state_next = frontend_pkg::fetch_wait;
                end
            end
            frontend_pkg::fetch_wait: begin
                // word is back, move on to the next one
                if (fetch_reply.valid) begin
                    state_next = frontend_pkg::fetch_idle;
                    pc_next    = pc + frontend_pkg::inst_bytes;
                end
            end
            default: begin
                state_next = frontend_pkg::fetch_idle;
            end
        endcase
    end

    ////////////////////
    // registers
    ////////////////////

    // FSM and pc
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= frontend_pkg::fetch_idle;
            pc    <= frontend_pkg::reset_pc;
        end else begin
            state <= state_next;
            pc    <= pc_next;
        end
    end

    // packet valid lasts one cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            packet_valid <= 1'b0;
        end else begin
            packet_valid <= reply_taken;
        end
    end

    // packet payload, captured with the reply
    always_ff @(posedge clock) begin
        if (reply_taken) begin
            packet_pc   <= pc;
            packet_inst <= reply_inst;
        end
    end

    assign fetch_packet.valid = packet_valid;
    assign fetch_packet.pc    = packet_pc;
    assign fetch_packet.inst  = packet_inst;

    ////////////////////
    // assertions
    ////////////////////

    // arbiter only accepts a fetch that we are requesting
    accept_only_when_idle: assert property (
        @(posedge clock) disable iff (reset)
        fetch_accepted |-> (state == frontend_pkg::fetch_idle)
    );

    // owner table never routes a reply to us without a fetch in flight
    reply_only_when_waiting: assert property (
        @(posedge clock) disable iff (reset)
        fetch_reply.valid |-> (state == frontend_pkg::fetch_wait)
    );

endmodule

//--- hw/mem_port_arbiter.sv
`timescale 1ns/1ns

module mem_port_arbiter (
    input  logic                                    clock,
    input  logic                                    reset,

    // load/store side
    input  frontend_pkg::mem_req_t                  data_req,
    output logic                                    data_accepted,
    output frontend_pkg::mem_reply_t                data_reply,

    // fetch side
    input  logic                                    fetch_request,
    input  logic [frontend_pkg::xlen-1:0]           fetch_addr,
    output logic                                    fetch_accepted,
    output frontend_pkg::mem_reply_t                fetch_reply,

    // tagged memory bus
    output frontend_pkg::mem_req_t                  mem_req,
    input  logic [frontend_pkg::mem_tag_width-1:0]  mem_response,
    input  logic [frontend_pkg::mem_tag_width-1:0]  mem_reply_tag,
    input  logic [frontend_pkg::mem_data_width-1:0] mem_reply_data
);

    ////////////////////
    // signals
    ////////////////////

    // data side holds a command this cycle
    logic data_active;

    // fetch side gets the bus this cycle
    logic fetch_active;

    // memory took whatever was on the bus
    logic bus_accepted;

    // accepted request is a load and needs an owner entry
    logic load_accepted;

    // owner recorded for a new load
    frontend_pkg::mem_owner_e req_owner;

    // owner of the tag of the incoming reply
    frontend_pkg::mem_owner_e reply_owner;

    // a reply is on the bus
    logic reply_present;

    // per-tag owner table, entry 0 stays unused
    frontend_pkg::mem_owner_e owner_table [frontend_pkg::num_mem_tags];

    ////////////////////
    // bus selection
    ////////////////////

    // data has priority, fetch stalls behind it
    assign data_active  = (data_req.command != frontend_pkg::bus_none);
    assign fetch_active = !data_active && fetch_request;

    always_comb begin
        if (data_active) begin
            mem_req = data_req;
        end else if (fetch_request) begin
            // fetch reads a whole beat at the pc
            mem_req.command = frontend_pkg::bus_load;
            mem_req.addr    = fetch_addr;
            mem_req.data    = '0;
        end else begin
            mem_req.command = frontend_pkg::bus_none;
            mem_req.addr    = '0;
            mem_req.data    = '0;
        end
    end

    ////////////////////
    // accept pulses
    ////////////////////

    // nonzero response tag means memory took it
    assign bus_accepted = (mem_response != '0);

    assign data_accepted  = data_active && bus_accepted;
    assign fetch_accepted = fetch_active && bus_accepted;

    // stores get a tag too but never reply
    assign load_accepted = bus_accepted && (mem_req.command == frontend_pkg::bus_load);

    always_comb begin
        if (data_active) begin
            req_owner = frontend_pkg::owner_data;
        end else begin
            req_owner = frontend_pkg::owner_fetch;
        end
    end

    ////////////////////
    // owner table
    ////////////////////

    // clear on reply, set on accepted load
    // set comes last so a tag reused in the same cycle keeps its new owner
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < frontend_pkg::num_mem_tags; i++) begin
                owner_table[i] <= frontend_pkg::owner_none;
            end
        end else begin
            if (reply_present) begin
                owner_table[mem_reply_tag] <= frontend_pkg::owner_none;
            end
            if (load_accepted) begin
                owner_table[mem_response] <= req_owner;
            end
        end
    end

    ////////////////////
    // reply routing
    ////////////////////

    assign reply_present = (mem_reply_tag != '0);
    assign reply_owner   = owner_table[mem_reply_tag];

    // data follows the bus, valid picks the side
    assign data_reply.valid  = reply_present && (reply_owner == frontend_pkg::owner_data);
    assign data_reply.data   = mem_reply_data;
    assign fetch_reply.valid = reply_present && (reply_owner == frontend_pkg::owner_fetch);
    assign fetch_reply.data  = mem_reply_data;

    ////////////////////
    // assertions
    ////////////////////

    // memory only replies under a tag that an earlier load was given
    reply_tag_owned: assert property (
        @(posedge clock) disable iff (reset)
        reply_present |-> (reply_owner != frontend_pkg::owner_none)
    );

    // memory does not reuse a tag before its reply, unless the reply is in this cycle
    response_tag_free: assert property (
        @(posedge clock) disable iff (reset)
        (bus_accepted && (mem_req.command != frontend_pkg::bus_none))
            |-> (owner_table[mem_response] == frontend_pkg::owner_none)
                || (mem_reply_tag == mem_response)
    );

endmodule

//--- hw/mem_frontend.sv
`timescale 1ns/1ns

module mem_frontend (
    input  logic                                    clock,
    input  logic                                    reset,

    // load/store side of the core
    input  frontend_pkg::mem_req_t                  data_req,
    output logic                                    data_accepted,
    output frontend_pkg::mem_reply_t                data_reply,

    // fetched instructions toward decode
    output frontend_pkg::fetch_packet_t             fetch_packet,

    // shared tagged memory bus
    output frontend_pkg::mem_req_t                  mem_req,
    input  logic [frontend_pkg::mem_tag_width-1:0]  mem_response,
    input  logic [frontend_pkg::mem_tag_width-1:0]  mem_reply_tag,
    input  logic [frontend_pkg::mem_data_width-1:0] mem_reply_data
);

    ////////////////////
    // fetch wires
    ////////////////////

    // fetch request level and its address
    logic                          fetch_request;
    logic [frontend_pkg::xlen-1:0] fetch_addr;

    // accept pulse, low while data holds the bus
    logic                          fetch_accepted;

    // reply routed back by tag
    frontend_pkg::mem_reply_t      fetch_reply;

    ////////////////////
    // fetch unit
    ////////////////////

    fetch_unit fetch_unit_0 (
        .clock          (clock),
        .reset          (reset),
        .fetch_request  (fetch_request),
        .fetch_addr     (fetch_addr),
        .fetch_accepted (fetch_accepted),
        .fetch_reply    (fetch_reply),
        .fetch_packet   (fetch_packet)
    );

    ////////////////////
    // bus arbiter
    ////////////////////

    // data first, then fetch, replies routed by owner table
    mem_port_arbiter mem_port_arbiter_0 (
        .clock          (clock),
        .reset          (reset),
        .data_req       (data_req),
        .data_accepted  (data_accepted),
        .data_reply     (data_reply),
        .fetch_request  (fetch_request),
        .fetch_addr     (fetch_addr),
        .fetch_accepted (fetch_accepted),
        .fetch_reply    (fetch_reply),
        .mem_req        (mem_req),
        .mem_response   (mem_response),
        .mem_reply_tag  (mem_reply_tag),
        .mem_reply_data (mem_reply_data)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // reset over the first 5 rising edges
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

//--- tb/mem_frontend_tb.sv
`timescale 1ns/1ns

module mem_frontend_tb;

    localparam int num_ops = 200;
    localparam int clock_period_ns = 4;
    localparam logic [31:0] data_base = 32'h8000_0000;
    localparam int tags = frontend_pkg::num_mem_tags;

    logic clock;
    logic reset;
    frontend_pkg::mem_req_t                  data_req;
    logic                                    data_accepted;
    frontend_pkg::mem_reply_t                data_reply;
    frontend_pkg::fetch_packet_t             fetch_packet;
    frontend_pkg::mem_req_t                  mem_req;
    logic [frontend_pkg::mem_tag_width-1:0]  mem_response;
    logic [frontend_pkg::mem_tag_width-1:0]  mem_reply_tag;
    logic [frontend_pkg::mem_data_width-1:0] mem_reply_data;

    ////////////////////
    // testbench state
    ////////////////////

    // responder memory fed from the bus
    logic [63:0] bus_mem [logic [28:0]];
    // model memory fed from the data port
    logic [63:0] model_mem [logic [28:0]];
    // per-tag bookkeeping of loads in flight
    logic                     tag_busy [tags];
    int                       tag_wait [tags];
    logic [63:0]              tag_data [tags];
    logic [63:0]              tag_expect [tags];
    frontend_pkg::mem_owner_e tag_owner [tags];
    // data stimulus
    frontend_pkg::mem_req_t cur_req;
    logic data_pending;
    int   data_gap;
    int   ops_sent;
    // fetch tracking
    logic        fetch_in_flight;
    logic        fetch_reply_last;
    logic [31:0] fetch_req_pc;
    logic [31:0] packet_pc;
    logic [3:0]  reply_tag_now;
    logic        seen_accept;
    // end of run counts
    int fetches_accepted;
    int fetch_packets;
    int data_loads;
    int data_replies;
    int checks [1:5];
    int errors [1:5];
    int total_checks;
    int total_errors;

    tb_clock_gen clock_gen (.clock(clock), .reset(reset));

    mem_frontend mem_frontend_i (
        .clock(clock), .reset(reset),
        .data_req(data_req), .data_accepted(data_accepted), .data_reply(data_reply),
        .fetch_packet(fetch_packet), .mem_req(mem_req), .mem_response(mem_response),
        .mem_reply_tag(mem_reply_tag), .mem_reply_data(mem_reply_data)
    );

    ////////////////////
    // helpers
    ////////////////////

    // never-written memory scrambled from the full beat address
    function automatic logic [63:0] fill_beat(input logic [31:0] addr);
        logic [31:0] beat;
        beat = {addr[31:3], 3'b000};
        return {beat ^ 32'ha5c3_0f1e, (beat * 32'h0001_0003) ^ 32'h3c96_e187};
    endfunction

    function automatic logic [63:0] model_beat(input logic [31:0] addr);
        return model_mem.exists(addr[31:3]) ? model_mem[addr[31:3]] : fill_beat(addr);
    endfunction

    function automatic logic [63:0] bus_beat(input logic [31:0] addr);
        return bus_mem.exists(addr[31:3]) ? bus_mem[addr[31:3]] : fill_beat(addr);
    endfunction

    // no load of either side still waits for its reply
    function automatic logic responder_idle();
        for (int t = 1; t < tags; t++) begin
            if (tag_busy[t]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic compare_hex(input int test, input string name,
                               input logic [63:0] got, input logic [63:0] expected);
        checks[test]++;
        assert (got === expected) else begin
            $display("[FAIL] %s got %h expected %h at %0t ns", name, got, expected, $time);
            errors[test]++;
        end
    endtask

    task automatic report_test(input int test, input string title);
        $display("test %0d %s: %0d checks, %0d errors", test, title, checks[test],
                 errors[test]);
    endtask

    ////////////////////
    // drive on the rising edge
    ////////////////////

    task automatic drive_cycle();
        logic [3:0] free_tag;
        free_tag      = '0;
        reply_tag_now = '0;
        // count down loads then reply under the lowest ready tag
        for (int t = 1; t < tags; t++) begin
            if (tag_busy[t] && tag_wait[t] > 0) tag_wait[t]--;
            if (tag_busy[t] && tag_wait[t] == 0 && reply_tag_now == '0) reply_tag_now = t;
            if (!tag_busy[t] && free_tag == '0) free_tag = t;
        end
        mem_reply_tag  <= reply_tag_now;
        mem_reply_data <= (reply_tag_now != '0) ? tag_data[reply_tag_now] : '0;
        // one request in four refused
        mem_response <= ($urandom_range(3) == 0) ? '0 : free_tag;
        // next data op after its idle gap
        if (!data_pending && data_gap > 0) begin
            data_gap--;
        end else if (!data_pending && ops_sent < num_ops) begin
            // eight beats in the data window
            cur_req.addr = data_base + 32'($urandom_range(7)) * 8;
            if ($urandom_range(1) == 0) begin
                cur_req.command = frontend_pkg::bus_store;
                cur_req.data    = {$urandom(), $urandom()};
            end else begin
                cur_req.command = frontend_pkg::bus_load;
                cur_req.data    = '0;
            end
            data_pending = 1'b1;
        end
        // held unchanged until accepted
        data_req <= data_pending ? cur_req : '0;
    endtask

    ////////////////////
    // check on the falling edge
    ////////////////////

    task automatic observe_cycle();
        logic accept_now;
        logic data_cmd;
        logic fetch_reply_now;
        logic [63:0] packet_beat;
        data_cmd        = (data_req.command != frontend_pkg::bus_none);
        accept_now      = (mem_response != '0) && (mem_req.command != frontend_pkg::bus_none);
        fetch_reply_now = 1'b0;
        if (!seen_accept && !accept_now) begin
            compare_hex(1, "fetch_packet.valid", fetch_packet.valid, 1'b0);
            compare_hex(1, "data_reply.valid", data_reply.valid, 1'b0);
            compare_hex(1, "data_accepted", data_accepted, 1'b0);
        end else if (!seen_accept) begin
            seen_accept = 1'b1;
            report_test(1, "reset outputs idle");
        end
        // data wins over a pending fetch
        if (data_cmd) begin
            compare_hex(3, "mem_req.command", mem_req.command, data_req.command);
            compare_hex(3, "mem_req.addr", mem_req.addr, data_req.addr);
            compare_hex(3, "mem_req.data", mem_req.data, data_req.data);
        end else if (!fetch_in_flight) begin
            compare_hex(3, "mem_req.command", mem_req.command, frontend_pkg::bus_load);
            compare_hex(3, "mem_req.addr", mem_req.addr, fetch_req_pc);
            compare_hex(3, "mem_req.data", mem_req.data, 64'h0);
        end else begin
            // fetch waits for its reply and nothing else wants the bus
            compare_hex(3, "mem_req.command", mem_req.command, frontend_pkg::bus_none);
        end
        compare_hex(3, "data_accepted", data_accepted, data_cmd && (mem_response != '0));
        // reply routing by recorded owner
        if (reply_tag_now != '0 && tag_owner[reply_tag_now] == frontend_pkg::owner_data) begin
            compare_hex(4, "data_reply.valid", data_reply.valid, 1'b1);
            compare_hex(4, "data_reply.data", data_reply.data, tag_expect[reply_tag_now]);
        end else begin
            compare_hex(4, "data_reply.valid", data_reply.valid, 1'b0);
        end
        // replies as the DUT hands them out
        if (data_reply.valid) begin
            data_replies++;
        end
        if (reply_tag_now != '0 && tag_owner[reply_tag_now] == frontend_pkg::owner_fetch) begin
            fetch_reply_now = 1'b1;
            fetch_in_flight = 1'b0;
            fetch_req_pc    = fetch_req_pc + frontend_pkg::inst_bytes;
        end
        if (reply_tag_now != '0) tag_busy[reply_tag_now] = 1'b0;
        // packet one cycle after its reply
        compare_hex(2, "fetch_packet.valid", fetch_packet.valid, fetch_reply_last);
        if (fetch_packet.valid) begin
            packet_beat = model_beat(packet_pc);
            fetch_packets++;
            compare_hex(2, "fetch_packet.pc", fetch_packet.pc, packet_pc);
            // pc bit 2 picks the upper word of the beat
            compare_hex(2, "fetch_packet.inst", fetch_packet.inst,
                        packet_pc[2] ? packet_beat[63:32] : packet_beat[31:0]);
            packet_pc = packet_pc + frontend_pkg::inst_bytes;
        end
        fetch_reply_last = fetch_reply_now;
        // what memory took this cycle
        if (accept_now && mem_req.command == frontend_pkg::bus_store) begin
            bus_mem[mem_req.addr[31:3]] = mem_req.data;
        end else if (accept_now) begin
            tag_busy[mem_response] = 1'b1;
            tag_wait[mem_response] = $urandom_range(8, 1);
            tag_data[mem_response] = bus_beat(mem_req.addr);
            if (data_cmd) begin
                tag_owner[mem_response]  = frontend_pkg::owner_data;
                tag_expect[mem_response] = model_beat(data_req.addr);
                data_loads++;
            end else begin
                tag_owner[mem_response] = frontend_pkg::owner_fetch;
                fetch_in_flight = 1'b1;
                fetches_accepted++;
            end
        end
        // model memory follows the data port
        if (data_cmd && mem_response != '0) begin
            if (data_req.command == frontend_pkg::bus_store) begin
                model_mem[data_req.addr[31:3]] = data_req.data;
            end
            data_pending = 1'b0;
            data_gap     = $urandom_range(3);
            ops_sent++;
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        void'($urandom(32'h66d80dda));
        data_req       = '0;
        mem_response   = '0;
        mem_reply_tag  = '0;
        mem_reply_data = '0;
        for (int t = 0; t < tags; t++) begin
            tag_busy[t] = 1'b0;
            tag_wait[t] = 0;
        end
        for (int i = 1; i <= 5; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
        data_pending = 1'b0;
        data_gap = 0;
        ops_sent = 0;
        fetch_in_flight = 1'b0;
        fetch_reply_last = 1'b0;
        fetch_req_pc = frontend_pkg::reset_pc;
        packet_pc = frontend_pkg::reset_pc;
        reply_tag_now = '0;
        seen_accept = 1'b0;
        fetches_accepted = 0;
        fetch_packets = 0;
        data_loads = 0;
        data_replies = 0;
        // outputs idle while reset is held
        @(negedge clock);
        compare_hex(1, "fetch_packet.valid", fetch_packet.valid, 1'b0);
        compare_hex(1, "data_reply.valid", data_reply.valid, 1'b0);
        compare_hex(1, "data_accepted", data_accepted, 1'b0);
        wait (reset == 1'b0);
        // stop once all ops are in and the last packet is out
        forever begin
            @(negedge clock);
            observe_cycle();
            if (ops_sent == num_ops && responder_idle() && !fetch_reply_last) break;
            @(posedge clock);
            drive_cycle();
        end
        compare_hex(5, "fetch packets", fetch_packets, fetches_accepted);
        compare_hex(5, "data replies", data_replies, data_loads);
        report_test(2, "fetch packets in order");
        report_test(3, "bus selection");
        report_test(4, "data replies");
        report_test(5, "no lost or duplicate requests");
        total_checks = 0;
        total_errors = 0;
        for (int i = 1; i <= 5; i++) begin
            total_checks += checks[i];
            total_errors += errors[i];
        end
        $display("totals: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog at 40 cycles per data op
    initial begin
        #(num_ops * 40 * clock_period_ns);
        $display("watchdog: run did not finish within %0d cycles", num_ops * 40);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- filelist.f
hw/frontend_pkg.sv
hw/fetch_unit.sv
hw/mem_port_arbiter.sv
hw/mem_frontend.sv
tb/tb_clock_gen.sv
tb/mem_frontend_tb.sv

//--- Bender.yml
package:
  name: mem_frontend

sources:
  - files:
      - hw/frontend_pkg.sv
      - hw/fetch_unit.sv
      - hw/mem_port_arbiter.sv
      - hw/mem_frontend.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/mem_frontend_tb.sv
